// File: verilog/spad_dma_pkg.sv
`default_nettype none

package spad_dma_pkg;

  localparam int ACCEL_COUNT = 4;
  localparam int DEST_WIDTH  = $clog2(ACCEL_COUNT);

  // One scratchpad line
  localparam int DATA_WIDTH = 32;
  localparam int LINE_BYTES = DATA_WIDTH / 8;
  localparam int MASK_BITS  = $clog2(LINE_BYTES);

  // 4 KB byte space, lines interleaved over two banks
  localparam int ADDR_WIDTH      = 12;
  localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - MASK_BITS;
  localparam int BANK_ADDR_WIDTH = LINE_ADDR_WIDTH - 1;

  // Lengths 1 to 255 bytes
  localparam int LEN_WIDTH      = 8;
  localparam int LINE_CNT_WIDTH = LEN_WIDTH - MASK_BITS + 1;

  localparam int FIFO_LINES = 2;
  localparam int OUT_WIDTH  = 8;

endpackage

`default_nettype wire

// File: verilog/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter int PORTS = 4
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire  [PORTS-1:0]          request,
  output logic [PORTS-1:0]          grant,
  output logic                      grant_valid,
  output logic [$clog2(PORTS)-1:0]  grant_encoded
);

  logic [$clog2(PORTS)-1:0] last_grant;

  // Search starts just above the last winner and wraps
  always_comb begin
    int idx;
    grant         = '0;
    grant_valid   = 1'b0;
    grant_encoded = '0;
    for (int off = 1; off <= PORTS; off++) begin
      idx = (int'(last_grant) + off) % PORTS;
      if (!grant_valid && request[idx]) begin
        grant[idx]    = 1'b1;
        grant_valid   = 1'b1;
        grant_encoded = $clog2(PORTS)'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_grant <= $clog2(PORTS)'(PORTS - 1);
    end else if (grant_valid) begin
      last_grant <= grant_encoded;
    end
  end

endmodule

`default_nettype wire

// File: verilog/line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 2
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              clear,
  input  wire              din_valid,
  input  wire  [WIDTH-1:0] din,
  output logic             dout_valid,
  output logic [WIDTH-1:0] dout,
  input  wire              dout_ready
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Extra top bit tells full from empty
  logic [$clog2(DEPTH):0] wr_ptr;
  logic [$clog2(DEPTH):0] rd_ptr;

  always_ff @(posedge clk) begin
    if (din_valid) begin
      mem[wr_ptr[$clog2(DEPTH)-1:0]] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (din_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (dout_valid && dout_ready) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign dout_valid = (wr_ptr != rd_ptr);
  assign dout       = mem[rd_ptr[$clog2(DEPTH)-1:0]];

endmodule

`default_nettype wire

// File: verilog/scratchpad_bank.sv
`timescale 1ns/1ps
`default_nettype none

module scratchpad_bank
  import spad_dma_pkg::*;
(
  input  wire                        clk,
  input  wire                        wr_en,
  input  wire  [BANK_ADDR_WIDTH-1:0] wr_addr,
  input  wire  [DATA_WIDTH-1:0]      wr_data,
  input  wire                        rd_en,
  input  wire  [BANK_ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0]      rd_data
);

  logic [DATA_WIDTH-1:0] mem [2**BANK_ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, data follows rd_en by one cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: verilog/rd_dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

module rd_dma_engine
  import spad_dma_pkg::*;
(
  input  wire                               clk,
  input  wire                               rst,
  input  wire  [DEST_WIDTH-1:0]             desc_accel_id,
  input  wire  [ADDR_WIDTH-1:0]             desc_addr,
  input  wire  [LEN_WIDTH-1:0]              desc_len,
  input  wire                               desc_valid,
  output logic [ACCEL_COUNT-1:0]            desc_error,
  input  wire  [ACCEL_COUNT-1:0]            accel_stop,
  output logic [ACCEL_COUNT-1:0]            accel_busy,
  output logic                              bank0_rd_en,
  output logic [BANK_ADDR_WIDTH-1:0]        bank0_rd_addr,
  output logic                              bank1_rd_en,
  output logic [BANK_ADDR_WIDTH-1:0]        bank1_rd_addr,
  input  wire  [DATA_WIDTH-1:0]             bank0_rd_data,
  input  wire  [DATA_WIDTH-1:0]             bank1_rd_data,
  output wire  [ACCEL_COUNT*DATA_WIDTH-1:0] line_data,
  output wire  [ACCEL_COUNT*MASK_BITS-1:0]  line_ptr,
  output wire  [ACCEL_COUNT-1:0]            line_last,
  output wire  [ACCEL_COUNT-1:0]            line_valid,
  input  wire  [ACCEL_COUNT-1:0]            line_ready
);

  typedef struct packed {
    logic [DEST_WIDTH-1:0] dest;
    logic                  last;
    logic [MASK_BITS-1:0]  ptr;
    logic [MASK_BITS-1:0]  offset;
    logic                  odd;
  } rd_meta_t;

  logic                       req_v;
  logic [DEST_WIDTH-1:0]      req_dest;
  logic [ACCEL_COUNT-1:0]     req_1hot;
  logic [LINE_ADDR_WIDTH-1:0] req_addr;
  logic [MASK_BITS-1:0]       req_offset;
  logic [MASK_BITS-1:0]       req_final_ptr;
  logic [LINE_CNT_WIDTH-1:0]  req_count;
  logic                       desc_busy;
  logic                       desc_take;
  logic [ACCEL_COUNT-1:0]     stop_r;

  logic [LINE_ADDR_WIDTH-1:0] act_addr [ACCEL_COUNT];
  logic [LINE_CNT_WIDTH-1:0]  act_count [ACCEL_COUNT];
  logic [MASK_BITS-1:0]       act_offset [ACCEL_COUNT];
  logic [MASK_BITS-1:0]       act_final_ptr [ACCEL_COUNT];
  logic [ACCEL_COUNT-1:0]     act_v;
  logic [ACCEL_COUNT-1:0]     credit_ok;
  logic [ACCEL_COUNT-1:0]     pop_last;

  logic [ACCEL_COUNT-1:0]     arb_grant;
  logic                       arb_valid;
  logic [DEST_WIDTH-1:0]      arb_enc;

  logic                       issue_v;
  logic [LINE_ADDR_WIDTH-1:0] iss_addr;
  logic [LINE_ADDR_WIDTH-1:0] iss_addr_n;
  logic [MASK_BITS-1:0]       iss_final;
  rd_meta_t                   iss_meta;
  rd_meta_t                   s1_meta, s2_meta, s3_meta, s4_meta;
  logic [4:1]                 s_v;
  logic [DATA_WIDTH-1:0]      b0_q, b1_q;
  logic [2*DATA_WIDTH-1:0]    pair;
  logic [DATA_WIDTH-1:0]      s4_data;

  // A descriptor still in the request stage counts as busy too
  assign desc_busy = accel_busy[desc_accel_id] || (req_v && req_dest == desc_accel_id);
  assign desc_take = desc_valid && !desc_busy;
  assign req_1hot  = ACCEL_COUNT'(1) << req_dest;

  always_ff @(posedge clk) begin
    req_dest      <= desc_accel_id;
    req_addr      <= desc_addr[ADDR_WIDTH-1:MASK_BITS];
    req_offset    <= desc_addr[MASK_BITS-1:0];
    req_count     <= LINE_CNT_WIDTH'(desc_len[LEN_WIDTH-1:MASK_BITS]) +
                     LINE_CNT_WIDTH'(desc_len[MASK_BITS-1:0] != '0);
    req_final_ptr <= desc_len[MASK_BITS-1:0] - 1'b1;
    if (rst) begin
      req_v <= 1'b0;
    end else begin
      req_v <= desc_take;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stop_r <= '0;
    end else begin
      stop_r <= (stop_r & ~(ACCEL_COUNT'(desc_take) << desc_accel_id)) | accel_stop;
    end
  end

  // Active table, a new request wins the write port
  always_ff @(posedge clk) begin
    if (req_v) begin
      act_addr[req_dest]      <= req_addr + 1'b1;
      act_count[req_dest]     <= req_count - 1'b1;
      act_offset[req_dest]    <= req_offset;
      act_final_ptr[req_dest] <= req_final_ptr;
    end else if (arb_valid) begin
      act_addr[arb_enc]  <= act_addr[arb_enc] + 1'b1;
      act_count[arb_enc] <= act_count[arb_enc] - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      act_v <= '0;
    end else begin
      act_v <= (act_v | ((req_v && req_count != 1) ? req_1hot : '0)) &
               ~((arb_valid && act_count[arb_enc] == 1) ? arb_grant : '0) & ~stop_r;
    end
  end

  rr_arbiter #(.PORTS(ACCEL_COUNT)) arb (
    .clk           (clk),
    .rst           (rst),
    .request       (req_v ? '0 : (act_v & credit_ok & ~stop_r)),
    .grant         (arb_grant),
    .grant_valid   (arb_valid),
    .grant_encoded (arb_enc)
  );

  assign issue_v    = req_v || arb_valid;
  assign iss_addr   = req_v ? req_addr : act_addr[arb_enc];
  assign iss_addr_n = iss_addr + 1'b1;
  assign iss_final  = req_v ? req_final_ptr : act_final_ptr[arb_enc];

  always_comb begin
    iss_meta.dest   = req_v ? req_dest : arb_enc;
    iss_meta.last   = req_v ? (req_count == 1) : (act_count[arb_enc] == 1);
    iss_meta.ptr    = iss_meta.last ? iss_final : '1;
    iss_meta.offset = req_v ? req_offset : act_offset[arb_enc];
    iss_meta.odd    = iss_addr[0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bank0_rd_en <= 1'b0;
      bank1_rd_en <= 1'b0;
      s_v         <= '0;
    end else begin
      bank0_rd_en <= issue_v;
      bank1_rd_en <= issue_v;
      s_v         <= {s_v[3:1], issue_v};
    end
  end

  // Addressed line and its successor, one from each bank
  assign pair = s3_meta.odd ? {b0_q, b1_q} : {b1_q, b0_q};

  always_ff @(posedge clk) begin
    bank0_rd_addr <= iss_addr[0] ? iss_addr_n[LINE_ADDR_WIDTH-1:1] :
                                   iss_addr[LINE_ADDR_WIDTH-1:1];
    bank1_rd_addr <= iss_addr[LINE_ADDR_WIDTH-1:1];
    s1_meta       <= iss_meta;
    s2_meta       <= s1_meta;
    s3_meta       <= s2_meta;
    s4_meta       <= s3_meta;
    b0_q          <= bank0_rd_data;
    b1_q          <= bank1_rd_data;
    s4_data       <= DATA_WIDTH'(pair >> (8 * s3_meta.offset));
  end

  for (genvar i = 0; i < ACCEL_COUNT; i++) begin : g_accel
    logic [$clog2(FIFO_LINES):0] credit;
    logic                        issue_hit;
    logic                        pop;

    assign issue_hit    = issue_v && (iss_meta.dest == DEST_WIDTH'(i));
    assign pop          = line_valid[i] && line_ready[i];
    assign pop_last[i]  = pop && line_last[i];
    assign credit_ok[i] = (credit < FIFO_LINES);

    // Lines issued and not yet popped
    always_ff @(posedge clk) begin
      if (rst || stop_r[i]) begin
        credit <= '0;
      end else if (issue_hit && !pop) begin
        credit <= credit + 1'b1;
      end else if (!issue_hit && pop) begin
        credit <= credit - 1'b1;
      end
    end

    line_fifo #(
      .WIDTH (DATA_WIDTH + MASK_BITS + 1),
      .DEPTH (FIFO_LINES)
    ) fifo (
      .clk        (clk),
      .rst        (rst),
      .clear      (stop_r[i]),
      .din_valid  (s_v[4] && s4_meta.dest == DEST_WIDTH'(i) && !stop_r[i]),
      .din        ({s4_meta.last, s4_meta.ptr, s4_data}),
      .dout_valid (line_valid[i]),
      .dout       ({line_last[i], line_ptr[i*MASK_BITS +: MASK_BITS],
                    line_data[i*DATA_WIDTH +: DATA_WIDTH]}),
      .dout_ready (line_ready[i])
    );
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      accel_busy <= '0;
    end else begin
      accel_busy <= (accel_busy | (req_v ? req_1hot : '0)) & ~pop_last & ~stop_r;
    end
  end

  // Sticky, the descriptor itself is dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_error <= '0;
    end else if (desc_valid && desc_busy) begin
      desc_error[desc_accel_id] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/width_conv.sv
`timescale 1ns/1ps
`default_nettype none

module width_conv
  import spad_dma_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [DATA_WIDTH-1:0] line_data,
  input  wire  [MASK_BITS-1:0]  line_ptr,
  input  wire                   line_last,
  input  wire                   line_valid,
  output logic                  line_ready,
  output logic [OUT_WIDTH-1:0]  out_data,
  output logic                  out_last,
  output logic                  out_valid,
  input  wire                   out_ready
);

  logic [MASK_BITS-1:0] idx;
  logic                 advance;
  logic                 last_chunk;

  // Output register is empty or being taken this cycle
  assign advance    = !out_valid || out_ready;
  assign last_chunk = (idx == line_ptr);
  assign line_ready = advance && last_chunk;

  // A dropped line_valid without a pop means the FIFO was flushed
  always_ff @(posedge clk) begin
    if (rst || !line_valid) begin
      idx <= '0;
    end else if (advance) begin
      idx <= last_chunk ? '0 : idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= line_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_data <= line_data[idx*OUT_WIDTH +: OUT_WIDTH];
      out_last <= line_last && last_chunk;
    end
  end

endmodule

`default_nettype wire

// File: verilog/spad_rd_top.sv
`timescale 1ns/1ps
`default_nettype none

module spad_rd_top
  import spad_dma_pkg::*;
(
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              wr_en,
  input  wire [LINE_ADDR_WIDTH-1:0]        wr_addr,
  input  wire [DATA_WIDTH-1:0]             wr_data,
  input  wire [DEST_WIDTH-1:0]             desc_accel_id,
  input  wire [ADDR_WIDTH-1:0]             desc_addr,
  input  wire [LEN_WIDTH-1:0]              desc_len,
  input  wire                              desc_valid,
  output wire [ACCEL_COUNT-1:0]            desc_error,
  input  wire [ACCEL_COUNT-1:0]            accel_stop,
  output wire [ACCEL_COUNT-1:0]            accel_busy,
  output wire [ACCEL_COUNT*OUT_WIDTH-1:0]  out_data,
  output wire [ACCEL_COUNT-1:0]            out_last,
  output wire [ACCEL_COUNT-1:0]            out_valid,
  input  wire [ACCEL_COUNT-1:0]            out_ready
);

  logic                              bank0_rd_en, bank1_rd_en;
  logic [BANK_ADDR_WIDTH-1:0]        bank0_rd_addr, bank1_rd_addr;
  logic [DATA_WIDTH-1:0]             bank0_rd_data, bank1_rd_data;
  wire  [ACCEL_COUNT*DATA_WIDTH-1:0] line_data;
  wire  [ACCEL_COUNT*MASK_BITS-1:0]  line_ptr;
  wire  [ACCEL_COUNT-1:0]            line_last, line_valid, line_ready;

  // Even lines in bank0, odd lines in bank1
  scratchpad_bank bank0 (
    .clk     (clk),
    .wr_en   (wr_en && !wr_addr[0]),
    .wr_addr (wr_addr[LINE_ADDR_WIDTH-1:1]),
    .wr_data (wr_data),
    .rd_en   (bank0_rd_en),
    .rd_addr (bank0_rd_addr),
    .rd_data (bank0_rd_data)
  );

  scratchpad_bank bank1 (
    .clk     (clk),
    .wr_en   (wr_en && wr_addr[0]),
    .wr_addr (wr_addr[LINE_ADDR_WIDTH-1:1]),
    .wr_data (wr_data),
    .rd_en   (bank1_rd_en),
    .rd_addr (bank1_rd_addr),
    .rd_data (bank1_rd_data)
  );

  rd_dma_engine engine (
    .clk           (clk),
    .rst           (rst),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .desc_valid    (desc_valid),
    .desc_error    (desc_error),
    .accel_stop    (accel_stop),
    .accel_busy    (accel_busy),
    .bank0_rd_en   (bank0_rd_en),
    .bank0_rd_addr (bank0_rd_addr),
    .bank1_rd_en   (bank1_rd_en),
    .bank1_rd_addr (bank1_rd_addr),
    .bank0_rd_data (bank0_rd_data),
    .bank1_rd_data (bank1_rd_data),
    .line_data     (line_data),
    .line_ptr      (line_ptr),
    .line_last     (line_last),
    .line_valid    (line_valid),
    .line_ready    (line_ready)
  );

  for (genvar i = 0; i < ACCEL_COUNT; i++) begin : g_conv
    width_conv conv (
      .clk        (clk),
      .rst        (rst),
      .line_data  (line_data[i*DATA_WIDTH +: DATA_WIDTH]),
      .line_ptr   (line_ptr[i*MASK_BITS +: MASK_BITS]),
      .line_last  (line_last[i]),
      .line_valid (line_valid[i]),
      .line_ready (line_ready[i]),
      .out_data   (out_data[i*OUT_WIDTH +: OUT_WIDTH]),
      .out_last   (out_last[i]),
      .out_valid  (out_valid[i]),
      .out_ready  (out_ready[i])
    );
  end

endmodule

`default_nettype wire

// File: sim/tb_spad_rd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spad_rd
  import spad_dma_pkg::*;
();

  localparam int SPAD_BYTES = 4096;
  localparam int SPAD_LINES = SPAD_BYTES / LINE_BYTES;
  // Fill takes 1024 cycles and the longest stream with random ready stays well under 2000
  localparam int TIMEOUT_CYCLES = 20000;

  logic                           clk;
  logic                           rst;
  logic                           wr_en;
  logic [LINE_ADDR_WIDTH-1:0]     wr_addr;
  logic [DATA_WIDTH-1:0]          wr_data;
  logic [DEST_WIDTH-1:0]          desc_accel_id;
  logic [ADDR_WIDTH-1:0]          desc_addr;
  logic [LEN_WIDTH-1:0]           desc_len;
  logic                           desc_valid;
  logic [ACCEL_COUNT-1:0]         accel_stop;
  logic [ACCEL_COUNT-1:0]         out_ready = '0;
  wire  [ACCEL_COUNT-1:0]         desc_error;
  wire  [ACCEL_COUNT-1:0]         accel_busy;
  wire  [ACCEL_COUNT*OUT_WIDTH-1:0] out_data;
  wire  [ACCEL_COUNT-1:0]         out_last;
  wire  [ACCEL_COUNT-1:0]         out_valid;

  integer seed = 27;
  logic [7:0] spad_bytes [SPAD_BYTES];

  // Per-accelerator expected stream
  logic                  chk_on [ACCEL_COUNT];
  logic [ADDR_WIDTH-1:0] exp_addr [ACCEL_COUNT];
  int                    exp_len [ACCEL_COUNT];
  int                    got_cnt [ACCEL_COUNT];

  // 0 holds ready low, 1 high, 2 random
  int    ready_mode = 0;
  int    cycles = 0;
  int    err_count = 0;
  int    errs_at_start;
  int    pass_tests = 0;
  int    fail_tests = 0;
  string test_name = "reset";

  spad_rd_top DUT (
    .clk           (clk),
    .rst           (rst),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .desc_valid    (desc_valid),
    .desc_error    (desc_error),
    .accel_stop    (accel_stop),
    .accel_busy    (accel_busy),
    .out_data      (out_data),
    .out_last      (out_last),
    .out_valid     (out_valid),
    .out_ready     (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Byte k of a stream starting at base in the host-side copy
  function automatic logic [7:0] expected_byte(input logic [ADDR_WIDTH-1:0] base, input int k);
    return spad_bytes[(int'(base) + k) % SPAD_BYTES];
  endfunction

  always @(posedge clk) begin
    if (ready_mode == 2) begin
      out_ready <= ACCEL_COUNT'($random(seed));
    end else if (ready_mode == 1) begin
      out_ready <= '1;
    end else begin
      out_ready <= '0;
    end
  end

  always @(posedge clk) begin : compare_bytes
    logic [7:0] exp_b;
    logic [7:0] act_b;
    logic       exp_l;
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      if (out_valid[i] && out_ready[i]) begin
        act_b = out_data[i*OUT_WIDTH +: OUT_WIDTH];
        if (!chk_on[i]) begin
          $display("Unexpected byte on accelerator %0d during %s", i, test_name);
          err_count++;
        end else begin
          exp_b = expected_byte(exp_addr[i], got_cnt[i]);
          exp_l = (got_cnt[i] == exp_len[i] - 1);
          if (act_b !== exp_b) begin
            $display("[FAIL] %s accel %0d byte %0d expected %02h actual %02h",
                     test_name, i, got_cnt[i], exp_b, act_b);
            err_count++;
          end
          if (out_last[i] !== exp_l) begin
            $display("[FAIL] %s accel %0d byte %0d out_last expected %0b actual %0b",
                     test_name, i, got_cnt[i], exp_l, out_last[i]);
            err_count++;
          end
          got_cnt[i]++;
          if (got_cnt[i] == exp_len[i]) begin
            chk_on[i] = 1'b0;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic begin_test(input string name);
    test_name     = name;
    errs_at_start = err_count;
  endtask

  task automatic end_test();
    if (err_count == errs_at_start) begin
      $display("[PASS] %s", test_name);
      pass_tests++;
    end else begin
      $display("[FAIL] %s finished with %0d errors", test_name, err_count - errs_at_start);
      fail_tests++;
    end
  endtask

  task automatic arm_check(input int a, input logic [ADDR_WIDTH-1:0] addr, input int len);
    exp_addr[a] = addr;
    exp_len[a]  = len;
    got_cnt[a]  = 0;
    chk_on[a]   = 1'b1;
  endtask

  // Leaves desc_valid high so that descriptors can follow back to back
  task automatic send_desc(input int a, input logic [ADDR_WIDTH-1:0] addr, input int len);
    @(posedge clk);
    desc_valid    <= 1'b1;
    desc_accel_id <= DEST_WIDTH'(a);
    desc_addr     <= addr;
    desc_len      <= LEN_WIDTH'(len);
  endtask

  task automatic end_desc();
    @(posedge clk);
    desc_valid <= 1'b0;
  endtask

  task automatic wait_done(input int a);
    while (chk_on[a]) begin
      @(negedge clk);
    end
  endtask

  task automatic check_idle(input int a);
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (accel_busy[a] !== 1'b0) begin
      $display("[FAIL] %s accel_busy[%0d] expected 0 actual %b", test_name, a, accel_busy[a]);
      err_count++;
    end
  endtask

  task automatic run_xfer(input int a, input logic [ADDR_WIDTH-1:0] addr, input int len);
    arm_check(a, addr, len);
    send_desc(a, addr, len);
    end_desc();
    wait_done(a);
    check_idle(a);
  endtask

  initial begin
    logic [DATA_WIDTH-1:0] word;
    bit                    valid_seen;
    rst           = 1'b1;
    wr_en         = 1'b0;
    wr_addr       = '0;
    wr_data       = '0;
    desc_valid    = 1'b0;
    desc_accel_id = '0;
    desc_addr     = '0;
    desc_len      = '0;
    accel_stop    = '0;
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      chk_on[i]  = 1'b0;
      got_cnt[i] = 0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Random fill of every line with a byte copy kept
    for (int l = 0; l < SPAD_LINES; l++) begin
      word = $random(seed);
      for (int b = 0; b < LINE_BYTES; b++) begin
        spad_bytes[l*LINE_BYTES + b] = word[8*b +: 8];
      end
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_addr <= LINE_ADDR_WIDTH'(l);
      wr_data <= word;
    end
    @(posedge clk);
    wr_en      <= 1'b0;
    ready_mode = 1;

    begin_test("aligned_64");
    run_xfer(0, 12'h100, 64);
    end_test();

    begin_test("unaligned_short");
    run_xfer(1, 12'h201, 1);
    run_xfer(1, 12'h202, 5);
    run_xfer(1, 12'h303, 130);
    end_test();

    begin_test("concurrent_four");
    ready_mode = 2;
    arm_check(0, 12'h040, 100);
    arm_check(1, 12'h0a3, 77);
    arm_check(2, 12'h131, 255);
    arm_check(3, 12'h2e2, 60);
    send_desc(0, 12'h040, 100);
    send_desc(1, 12'h0a3, 77);
    send_desc(2, 12'h131, 255);
    send_desc(3, 12'h2e2, 60);
    end_desc();
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      wait_done(i);
    end
    ready_mode = 1;
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      check_idle(i);
    end
    end_test();

    begin_test("busy_error");
    arm_check(1, 12'h010, 200);
    send_desc(1, 12'h010, 200);
    end_desc();
    repeat (2) @(posedge clk);
    send_desc(1, 12'h080, 16);
    end_desc();
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (desc_error !== 4'b0010) begin
      $display("[FAIL] %s desc_error expected %b actual %b", test_name, 4'b0010, desc_error);
      err_count++;
    end
    wait_done(1);
    check_idle(1);
    end_test();

    begin_test("stop_restart");
    arm_check(2, 12'h180, 200);
    send_desc(2, 12'h180, 200);
    end_desc();
    while (got_cnt[2] < 20) begin
      @(negedge clk);
    end
    @(posedge clk);
    accel_stop <= 4'b0100;
    @(posedge clk);
    accel_stop <= '0;
    repeat (6) @(posedge clk);
    @(negedge clk);
    if (accel_busy[2] !== 1'b0) begin
      $display("[FAIL] %s accel_busy[2] expected 0 actual %b", test_name, accel_busy[2]);
      err_count++;
    end
    chk_on[2] = 1'b0;
    valid_seen = 1'b0;
    repeat (20) begin
      @(negedge clk);
      if (out_valid[2] !== 1'b0) begin
        valid_seen = 1'b1;
      end
    end
    if (valid_seen) begin
      $display("out_valid for accelerator 2 went high after the stop");
      err_count++;
    end
    run_xfer(2, 12'h0c5, 33);
    end_test();

    $display("Tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
verilog/spad_dma_pkg.sv
verilog/rr_arbiter.sv
verilog/line_fifo.sv
verilog/scratchpad_bank.sv
verilog/rd_dma_engine.sv
verilog/width_conv.sv
verilog/spad_rd_top.sv
sim/tb_spad_rd.sv
